//--- bench/calc_tb.sv
`timescale 1ns/1ps
`include "calc_defines.svh"

module calc_tb;

    // digits, chain, neg, wrap + random, back-pressure, clear
    localparam int TOTAL_PRESSES   = 3 + 11 + 6 + 9 + 40 + 12 + 11;
    localparam int WATCHDOG_CYCLES = TOTAL_PRESSES * (`CALC_DEBOUNCE + 60) + 16 + 200;

    logic                  clk = 1'b0;
    logic                  nRST;
    logic [3:0]            row;
    logic [3:0]            col;
    logic                  disp_valid;
    logic                  disp_neg;
    calc_pkg::bcd_t        disp_bcd;
    logic                  disp_ready;

    logic                  key_down;       // keypad model, one key at a time
    keypad_pkg::key_code_t key_sel;
    logic                  pending;        // a press waits for its display result
    logic                  exp_neg;
    calc_pkg::bcd_t        exp_bcd;
    logic                  bp_on;          // random stalls on disp_ready
    logic                  last_neg;       // last result taken by the display
    calc_pkg::bcd_t        last_bcd;
    int                    cyc;
    string                 test_name;

    calc_pkg::value_t      m_operand;      // reference model state
    calc_pkg::value_t      m_acc;
    int                    m_pend;         // 0 none, 1 add, 2 sub, 3 mul
    bit                    m_typed;        // digit entered since last operator

    calc_top i_dut (
        .clk(clk), .nRST(nRST), .row(row), .col(col),
        .disp_valid(disp_valid), .disp_neg(disp_neg), .disp_bcd(disp_bcd),
        .disp_ready(disp_ready)
    );

    always #2 clk = ~clk;   // 4 ns period

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // pressed key shorts its row to the column driven low
    always_comb begin
        row = 4'hF;
        if (key_down && !col[key_sel[1:0]]) begin
            row[key_sel[3:2]] = 1'b0;
        end
    end

    always @(posedge clk) begin
        disp_ready <= !bp_on || ($urandom_range(0, 1) == 1);
    end

    // held in reset: first column active, no result
    assert property (@(posedge clk) (!nRST && cyc > 1) |-> (col == 4'b1110 && !disp_valid))
        else begin
            $display("%s: col or disp_valid wrong while reset is held", test_name);
            $display("=== FAIL ===");
            $fatal(1, "reset state");
        end

    // rows high for two cycles means scanning, low column steps up by one
    assert property (@(posedge clk) disable iff (!nRST)
                     (row == 4'hF && $past(row) == 4'hF) |=>
                     (col == {$past(col[2:0]), $past(col[3])}))
        else begin
            $display("%s: scanner column did not step while no key was down", test_name);
            $display("=== FAIL ===");
            $fatal(1, "column scan");
        end

    // a low row freezes the column
    assert property (@(posedge clk) disable iff (!nRST) (row != 4'hF) |=> $stable(col))
        else begin
            $display("%s: scanner column moved while a row read low", test_name);
            $display("=== FAIL ===");
            $fatal(1, "column freeze");
        end

    // every result belongs to one press, nothing lost or repeated
    assert property (@(posedge clk) disable iff (!nRST) disp_valid |-> pending)
        else begin
            $display("%s: display result appeared with no key press waiting for it", test_name);
            $display("=== FAIL ===");
            $fatal(1, "unexpected result");
        end

    assert property (@(posedge clk) disable iff (!nRST)
                     disp_valid |-> (disp_neg == exp_neg && disp_bcd == exp_bcd))
        else begin
            $display("mismatch %s expected neg=%0b bcd=%05h actual neg=%0b bcd=%05h",
                     test_name, exp_neg, exp_bcd, disp_neg, disp_bcd);
            $display("=== FAIL ===");
            $fatal(1, "display value");
        end

    // stalled result must hold still
    assert property (@(posedge clk) disable iff (!nRST)
                     (disp_valid && !disp_ready) |=>
                     (disp_valid && $stable(disp_neg) && $stable(disp_bcd)))
        else begin
            $display("%s: display result changed or dropped while disp_ready was low", test_name);
            $display("=== FAIL ===");
            $fatal(1, "back-pressure");
        end

    function automatic calc_pkg::bcd_t to_bcd(input calc_pkg::value_t v);
        calc_pkg::bcd_t b;
        int             mag;
        b   = '0;
        mag = (v < 0) ? -int'(v) : int'(v);   // int holds 32768
        for (int i = 0; i < 5; i++) begin
            b[4*i +: 4] = 4'(mag % 10);
            mag         = mag / 10;
        end
        return b;
    endfunction

    function automatic calc_pkg::value_t fold_pending();
        case (m_pend)
            1: return calc_pkg::value_t'(m_acc + m_operand);
            2: return calc_pkg::value_t'(m_acc - m_operand);
            3: return calc_pkg::value_t'(m_acc * m_operand);   // wraps
            default: return m_typed ? m_operand : m_acc;     // nothing typed keeps acc
        endcase
    endfunction

    task automatic model_key(input keypad_pkg::key_code_t k, output calc_pkg::value_t shown);
        int r;
        int c;
        r = int'(k[3:2]);
        c = int'(k[1:0]);
        if ((r < 3 && c < 3) || k == 4'd13) begin   // digit keys, 0 sits under 8
            m_operand = calc_pkg::value_t'(m_operand * 10 + ((k == 4'd13) ? 0 : r * 3 + c + 1));
            m_typed   = 1'b1;
            shown     = m_operand;
        end else if (k == 4'd15) begin             // D
            m_operand = -m_operand;
            shown     = m_operand;
        end else if (k == 4'd14) begin             // #
            m_operand = '0;
            m_acc     = '0;
            m_pend    = 0;
            m_typed   = 1'b0;
            shown     = '0;
        end else begin                             // A, B, C or *
            m_acc     = fold_pending();
            m_pend    = (k == 4'd12) ? 0 : r + 1;
            m_operand = '0;
            m_typed   = 1'b0;
            shown     = m_acc;
        end
    endtask

    function automatic keypad_pkg::key_code_t code_of(input byte ch);
        string layout;
        int    idx;
        layout = "123A456B789C*0#D";   // row by row from the top
        idx    = 0;
        for (int i = 0; i < 16; i++) begin
            if (layout[i] == ch) begin
                idx = i;
            end
        end
        return keypad_pkg::key_code_t'(idx);
    endfunction

    task automatic press_key(input keypad_pkg::key_code_t k);
        calc_pkg::value_t shown;
        model_key(k, shown);
        @(posedge clk);
        key_sel  <= k;
        key_down <= 1'b1;
        exp_neg  <= (shown < 0);
        exp_bcd  <= to_bcd(shown);
        pending  <= 1'b1;
        do begin
            @(negedge clk);   // outputs settled here
        end while (!(disp_valid && disp_ready));
        last_neg = disp_neg;
        last_bcd = disp_bcd;
        @(posedge clk);       // transfer edge
        key_down <= 1'b0;
        pending  <= 1'b0;
        repeat ($urandom_range(1, 4)) @(posedge clk);
    endtask

    task automatic type_keys(input string s);
        for (int i = 0; i < s.len(); i++) begin
            press_key(code_of(s[i]));
        end
    endtask

    task automatic random_keys(input int n);
        for (int i = 0; i < n; i++) begin
            press_key(keypad_pkg::key_code_t'($urandom_range(0, 15)));
        end
    endtask

    task automatic check_shown(input int expv);
        calc_pkg::value_t v;
        v = calc_pkg::value_t'(expv);
        assert (last_neg == (v < 0) && last_bcd == to_bcd(v))
            else begin
                $display("mismatch %s expected %0d actual neg=%0b bcd=%05h",
                         test_name, expv, last_neg, last_bcd);
                $display("=== FAIL ===");
                $fatal(1, "shown value");
            end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: no display result arrived in time after %0d cycles", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(9));
        nRST       = 1'b0;
        disp_ready = 1'b1;
        key_down   = 1'b0;
        key_sel    = '0;
        pending    = 1'b0;
        exp_neg    = 1'b0;
        exp_bcd    = '0;
        bp_on      = 1'b0;
        cyc        = 0;
        m_operand  = '0;
        m_acc      = '0;
        m_pend     = 0;
        m_typed    = 1'b0;
        test_name  = "reset";
        repeat (16) @(posedge clk);
        nRST <= 1'b1;

        test_name = "digits";
        type_keys("4");
        check_shown(4);
        type_keys("2");
        check_shown(42);
        type_keys("7");
        check_shown(427);

        test_name = "chain";
        type_keys("#12A30B5C3*");
        check_shown(111);

        test_name = "negate";
        type_keys("#9D");
        check_shown(-9);
        type_keys("A4*");
        check_shown(-5);

        test_name = "random";
        type_keys("#999C999*");
        check_shown(14961);   // 998001 mod 65536
        random_keys(40);

        test_name = "backpressure";
        @(posedge clk);
        bp_on <= 1'b1;
        random_keys(12);
        bp_on <= 1'b0;

        test_name = "clear";
        random_keys(6);
        type_keys("#");
        check_shown(0);
        type_keys("3A4*");
        check_shown(7);

        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- common/calc_defines.svh
`ifndef CALC_DEFINES_SVH
`define CALC_DEFINES_SVH

// cycles a row must stay low before a press counts
`define CALC_DEBOUNCE 10

// calculator word width, two's complement
`define CALC_WIDTH 16

`endif

//--- common/calc_pkg.sv
`include "calc_defines.svh"

package calc_pkg;

    typedef logic signed [`CALC_WIDTH-1:0] value_t;   // wraps, no overflow flag
    typedef logic [3:0] digit_t;                       // one decimal / BCD digit
    typedef logic [19:0] bcd_t;                        // five digits, lsd in [3:0]

    typedef enum logic [2:0] {
        TK_DIGIT,
        TK_OP,      // add, sub, mul or neg
        TK_EQUAL,
        TK_CLEAR
    } token_e;

    typedef enum logic [2:0] {
        OP_NONE,
        OP_ADD,
        OP_SUB,
        OP_MUL,
        OP_NEG      // applied at once to the operand, never pending
    } op_e;

endpackage

//--- common/keypad_pkg.sv
package keypad_pkg;

    // key index, row * 4 + column
    typedef logic [3:0] key_code_t;

    // scanner FSM
    typedef enum logic [1:0] {
        SCAN,       // walking the columns
        DEBOUNCE,   // column frozen, counting low cycles
        OFFER,      // key code waiting for the handshake
        RELEASE     // waiting for all rows high
    } scan_state_e;

endpackage

//--- keypad/key_decode.sv
`timescale 1ns/1ps

module key_decode (
    input  logic                  key_valid,
    input  keypad_pkg::key_code_t key_code,
    output logic                  key_ready,
    output logic                  tok_valid,
    output calc_pkg::token_e      tok_kind,
    output calc_pkg::digit_t      tok_digit,
    output calc_pkg::op_e         tok_op,
    input  logic                  tok_ready
);

    // pure translation, handshake straight through
    assign tok_valid = key_valid;
    assign key_ready = tok_ready;

    always_comb begin
        tok_kind  = calc_pkg::TK_DIGIT;
        tok_digit = 4'd0;
        tok_op    = calc_pkg::OP_NONE;
        case (key_code)
            4'd0:  tok_digit = 4'd1;
            4'd1:  tok_digit = 4'd2;
            4'd2:  tok_digit = 4'd3;
            4'd4:  tok_digit = 4'd4;
            4'd5:  tok_digit = 4'd5;
            4'd6:  tok_digit = 4'd6;
            4'd8:  tok_digit = 4'd7;
            4'd9:  tok_digit = 4'd8;
            4'd10: tok_digit = 4'd9;
            4'd13: tok_digit = 4'd0;
            4'd3: begin                 // A
                tok_kind = calc_pkg::TK_OP;
                tok_op   = calc_pkg::OP_ADD;
            end
            4'd7: begin                 // B
                tok_kind = calc_pkg::TK_OP;
                tok_op   = calc_pkg::OP_SUB;
            end
            4'd11: begin                // C
                tok_kind = calc_pkg::TK_OP;
                tok_op   = calc_pkg::OP_MUL;
            end
            4'd15: begin                // D
                tok_kind = calc_pkg::TK_OP;
                tok_op   = calc_pkg::OP_NEG;
            end
            4'd12: tok_kind = calc_pkg::TK_EQUAL;   // *
            default: tok_kind = calc_pkg::TK_CLEAR; // # is code 14
        endcase
    end

endmodule

//--- keypad/keypad_scan.sv
`timescale 1ns/1ps
`include "calc_defines.svh"

module keypad_scan (
    input  logic                  clk,
    input  logic                  nRST,
    input  logic [3:0]            row,        // pulled up, low when pressed
    output logic [3:0]            col,        // active column driven low
    output logic                  key_valid,
    output keypad_pkg::key_code_t key_code,
    input  logic                  key_ready
);

    localparam int CNT_W = $clog2(`CALC_DEBOUNCE + 1);

    keypad_pkg::scan_state_e state;
    logic [1:0]       col_idx;     // active column
    logic [1:0]       row_idx;     // lowest row reading low
    logic             any_low;     // some key down in active column
    logic             accept;      // debounce finished this cycle
    logic [CNT_W-1:0] db_cnt;      // consecutive low cycles seen so far

    assign col = ~(4'b0001 << col_idx);   // 1110 after reset
    assign any_low = ~&row;
    assign key_valid = (state == keypad_pkg::OFFER);

    // priority to the lowest row, two keys at once are not detected
    always_comb begin
        row_idx = 2'd0;
        for (int r = 3; r >= 0; r--) begin
            if (!row[r]) begin
                row_idx = 2'(r);
            end
        end
    end

    assign accept = (state == keypad_pkg::DEBOUNCE) && any_low &&
                    (db_cnt == CNT_W'(`CALC_DEBOUNCE - 1));

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state   <= keypad_pkg::SCAN;
            col_idx <= 2'd0;
            db_cnt  <= '0;
        end else begin
            case (state)
                keypad_pkg::SCAN: begin
                    if (any_low) begin
                        state  <= keypad_pkg::DEBOUNCE;   // column freezes here
                        db_cnt <= CNT_W'(1);              // first low cycle
                    end else begin
                        col_idx <= col_idx + 2'd1;        // wraps 3 -> 0
                    end
                end
                keypad_pkg::DEBOUNCE: begin
                    if (!any_low) begin
                        state <= keypad_pkg::SCAN;        // bounce, resume scan
                    end else if (accept) begin
                        state <= keypad_pkg::OFFER;
                    end else begin
                        db_cnt <= db_cnt + CNT_W'(1);
                    end
                end
                keypad_pkg::OFFER: begin
                    if (key_ready) begin
                        state <= keypad_pkg::RELEASE;
                    end
                end
                default: begin
                    // held key stays here, no repeat
                    if (!any_low) begin
                        state <= keypad_pkg::SCAN;
                    end
                end
            endcase
        end
    end

    // code latched once, stable through OFFER
    always_ff @(posedge clk) begin
        if (accept) begin
            key_code <= {row_idx, col_idx};   // row * 4 + col
        end
    end

endmodule

//--- logic/calc_execute.sv
`timescale 1ns/1ps

module calc_execute (
    input  logic             clk,
    input  logic             nRST,
    input  logic             tok_valid,
    input  calc_pkg::token_e tok_kind,
    input  calc_pkg::digit_t tok_digit,
    input  calc_pkg::op_e    tok_op,
    output logic             tok_ready,
    output logic             val_valid,
    output calc_pkg::value_t val,
    input  logic             val_ready
);

    calc_pkg::value_t operand, operand_next;   // number being typed
    calc_pkg::value_t acc, acc_next;           // running result
    calc_pkg::value_t show;                    // value offered after this token
    calc_pkg::op_e    pend_op, pend_next;      // operator waiting for its rhs
    logic             started, started_next;   // digit typed since last op/equal
    logic             take;

    // pending op on acc and operand, all arithmetic wraps
    function automatic calc_pkg::value_t apply_op(input calc_pkg::op_e    op,
                                                  input calc_pkg::value_t a,
                                                  input calc_pkg::value_t b,
                                                  input logic             b_started);
        calc_pkg::value_t r;
        case (op)
            calc_pkg::OP_ADD: r = a + b;
            calc_pkg::OP_SUB: r = a - b;
            calc_pkg::OP_MUL: r = a * b;        // low half of product
            default:          r = b_started ? b : a;   // keeps result after equals
        endcase
        return r;
    endfunction

    assign tok_ready = !val_valid;   // one-entry output register
    assign take      = tok_valid && tok_ready;

    always_comb begin
        operand_next = operand;
        acc_next     = acc;
        pend_next    = pend_op;
        started_next = started;
        show         = operand;
        case (tok_kind)
            calc_pkg::TK_DIGIT: begin
                operand_next = operand * calc_pkg::value_t'(10) + calc_pkg::value_t'(tok_digit);
                started_next = 1'b1;
                show         = operand_next;
            end
            calc_pkg::TK_OP: begin
                if (tok_op == calc_pkg::OP_NEG) begin
                    operand_next = -operand;       // sign change, operand stays open
                    show         = operand_next;
                end else begin
                    acc_next     = apply_op(pend_op, acc, operand, started);
                    pend_next    = tok_op;
                    operand_next = '0;
                    started_next = 1'b0;
                    show         = acc_next;
                end
            end
            calc_pkg::TK_EQUAL: begin
                acc_next     = apply_op(pend_op, acc, operand, started);
                pend_next    = calc_pkg::OP_NONE;
                operand_next = '0;
                started_next = 1'b0;
                show         = acc_next;
            end
            default: begin                         // clear
                acc_next     = '0;
                pend_next    = calc_pkg::OP_NONE;
                operand_next = '0;
                started_next = 1'b0;
                show         = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            operand   <= '0;
            acc       <= '0;
            pend_op   <= calc_pkg::OP_NONE;
            started   <= 1'b0;
            val_valid <= 1'b0;
        end else begin
            if (take) begin
                operand   <= operand_next;
                acc       <= acc_next;
                pend_op   <= pend_next;
                started   <= started_next;
                val_valid <= 1'b1;                 // value out one cycle later
            end else if (val_ready) begin
                val_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            val <= show;
        end
    end

endmodule

//--- logic/calc_top.sv
`timescale 1ns/1ps

module calc_top (
    input  logic           clk,
    input  logic           nRST,
    input  logic [3:0]     row,
    output logic [3:0]     col,
    output logic           disp_valid,
    output logic           disp_neg,
    output calc_pkg::bcd_t disp_bcd,
    input  logic           disp_ready
);

    logic                  key_valid;    // scanner -> decoder
    logic                  key_ready;
    keypad_pkg::key_code_t key_code;
    logic                  tok_valid;    // decoder -> execute
    logic                  tok_ready;
    calc_pkg::token_e      tok_kind;
    calc_pkg::digit_t      tok_digit;
    calc_pkg::op_e         tok_op;
    logic                  val_valid;    // execute -> formatter
    logic                  val_ready;
    calc_pkg::value_t      val;

    keypad_scan i_scan (
        .clk(clk), .nRST(nRST), .row(row), .col(col),
        .key_valid(key_valid), .key_code(key_code), .key_ready(key_ready)
    );

    key_decode i_decode (
        .key_valid(key_valid), .key_code(key_code), .key_ready(key_ready),
        .tok_valid(tok_valid), .tok_kind(tok_kind), .tok_digit(tok_digit),
        .tok_op(tok_op), .tok_ready(tok_ready)
    );

    calc_execute i_exec (
        .clk(clk), .nRST(nRST),
        .tok_valid(tok_valid), .tok_kind(tok_kind), .tok_digit(tok_digit),
        .tok_op(tok_op), .tok_ready(tok_ready),
        .val_valid(val_valid), .val(val), .val_ready(val_ready)
    );

    result_format i_fmt (
        .clk(clk), .nRST(nRST),
        .val_valid(val_valid), .val(val), .val_ready(val_ready),
        .disp_valid(disp_valid), .disp_neg(disp_neg), .disp_bcd(disp_bcd),
        .disp_ready(disp_ready)
    );

endmodule

//--- logic/result_format.sv
`timescale 1ns/1ps

module result_format (
    input  logic             clk,
    input  logic             nRST,
    input  logic             val_valid,
    input  calc_pkg::value_t val,
    output logic             val_ready,
    output logic             disp_valid,
    output logic             disp_neg,
    output calc_pkg::bcd_t   disp_bcd,
    input  logic             disp_ready
);

    localparam int W     = $bits(calc_pkg::value_t);
    localparam int CNT_W = $clog2(W);

    typedef enum logic [1:0] {
        FMT_IDLE,
        FMT_LOAD,    // sign split, magnitude taken
        FMT_SHIFT,   // one double-dabble step per cycle
        FMT_DONE     // result held for the display
    } fmt_state_e;

    fmt_state_e       state;
    logic [CNT_W-1:0] step;       // shift steps done
    logic [W-1:0]     bin;        // raw value, then magnitude being shifted out
    calc_pkg::bcd_t   bcd;
    calc_pkg::bcd_t   bcd_adj;    // digits >= 5 bumped by 3
    logic             neg;

    assign val_ready  = (state == FMT_IDLE);
    assign disp_valid = (state == FMT_DONE);
    assign disp_neg   = neg;
    assign disp_bcd   = bcd;

    always_comb begin
        bcd_adj = bcd;
        for (int d = 0; d < 5; d++) begin
            if (bcd[4*d +: 4] >= 4'd5) begin
                bcd_adj[4*d +: 4] = bcd[4*d +: 4] + 4'd3;
            end
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state <= FMT_IDLE;
            step  <= '0;
        end else begin
            case (state)
                FMT_IDLE: begin
                    if (val_valid) begin
                        state <= FMT_LOAD;
                    end
                end
                FMT_LOAD: begin
                    state <= FMT_SHIFT;
                    step  <= '0;
                end
                FMT_SHIFT: begin
                    step <= step + CNT_W'(1);
                    if (step == CNT_W'(W - 1)) begin
                        state <= FMT_DONE;   // 17 cycles after the transfer
                    end
                end
                default: begin
                    if (disp_ready) begin
                        state <= FMT_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            FMT_IDLE: begin
                if (val_valid) begin
                    bin <= val;
                end
            end
            FMT_LOAD: begin
                neg <= bin[W-1];
                bin <= bin[W-1] ? -bin : bin;    // -32768 gives 32768, fits unsigned
                bcd <= '0;
            end
            FMT_SHIFT: begin
                bcd <= {bcd_adj[18:0], bin[W-1]};   // msb of magnitude first
                bin <= bin << 1;
            end
            default: ;
        endcase
    end

endmodule

//--- run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module calc_tb -f vlog.f -o calc_sim \
    && ./obj_dir/calc_sim | tee /dev/stderr | grep -xF "=== PASS ===" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- vlog.f
+incdir+common
common/keypad_pkg.sv
common/calc_pkg.sv
keypad/keypad_scan.sv
keypad/key_decode.sv
logic/calc_execute.sv
logic/result_format.sv
logic/calc_top.sv
bench/calc_tb.sv
